//--- src/axi_bridge_defines.svh
`ifndef AXI_BRIDGE_DEFINES_SVH
`define AXI_BRIDGE_DEFINES_SVH

// Full AXI and AXI4-Lite bus widths
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define AXI_ID_W   4

// Outstanding transactions per direction, also the depth of every bridge FIFO
`define AXI_MAX_TXNS 4

// Memory size in 32-bit words
// Byte addresses from MEM_WORDS*4 upward answer SLVERR
`define MEM_WORDS 256

`endif

//--- src/axi_bridge_pkg.sv
`default_nettype none

`include "axi_bridge_defines.svh"

package axi_bridge_pkg;

  // Basic field types
  typedef logic [`AXI_ADDR_W-1:0]   addr_t;
  typedef logic [`AXI_DATA_W-1:0]   data_t;
  typedef logic [`AXI_DATA_W/8-1:0] strb_t;
  typedef logic [`AXI_ID_W-1:0]     id_t;
  typedef logic [7:0]               len_t;
  typedef logic [2:0]               size_t;
  typedef logic [2:0]               prot_t;
  typedef logic [5:0]               atop_t;

  typedef logic [1:0] burst_t;
  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;

  typedef logic [1:0] resp_t;
  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Full AXI channels
  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    prot_t  prot;
    atop_t  atop;
  } aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  typedef struct packed {
    id_t    id;
    addr_t  addr;
    len_t   len;
    size_t  size;
    burst_t burst;
    prot_t  prot;
  } ar_chan_t;

  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_rsp_t;

  // AXI4-Lite channels
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_aw_chan_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } lite_w_chan_t;

  typedef struct packed {
    resp_t resp;
  } lite_b_chan_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } lite_ar_chan_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } lite_r_chan_t;

  typedef struct packed {
    lite_aw_chan_t aw;
    logic          aw_valid;
    lite_w_chan_t  w;
    logic          w_valid;
    logic          b_ready;
    lite_ar_chan_t ar;
    logic          ar_valid;
    logic          r_ready;
  } lite_req_t;

  typedef struct packed {
    logic          aw_ready;
    logic          w_ready;
    lite_b_chan_t  b;
    logic          b_valid;
    logic          ar_ready;
    lite_r_chan_t  r;
    logic          r_valid;
  } lite_rsp_t;

  // One outstanding burst in the splitter
  // beats is the burst len, resp the response collected so far
  typedef struct packed {
    len_t  beats;
    resp_t resp;
  } burst_rec_t;

endpackage

`default_nettype wire

//--- src/bridge_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module bridge_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic push_i,
  input  T     data_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             do_push;
  logic             do_pop;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);

  // A push into a full FIFO or a pop from an empty one is ignored
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head entry
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (do_pop && !do_push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_burst_splitter.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_defines.svh"

module axi_burst_splitter (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  axi_bridge_pkg::axi_req_t slv_req_i,
  output axi_bridge_pkg::axi_rsp_t slv_rsp_o,
  output axi_bridge_pkg::axi_req_t mst_req_o,
  input  axi_bridge_pkg::axi_rsp_t mst_rsp_i
);
  import axi_bridge_pkg::*;

  // Active burst per direction, len counts the beats still to issue
  aw_chan_t   aw_q;
  ar_chan_t   ar_q;
  logic       aw_busy_q;
  logic       ar_busy_q;
  logic       aw_take;
  logic       ar_take;
  logic       aw_beat;
  logic       ar_beat;

  // Bookkeeping of bursts waiting for their responses
  burst_rec_t wr_rec;
  burst_rec_t rd_rec;
  burst_rec_t wr_head;
  burst_rec_t rd_head;
  logic       wr_full;
  logic       wr_empty;
  logic       rd_full;
  logic       rd_empty;
  logic       wr_pop;
  logic       rd_pop;

  // Response counting against the head record
  len_t       b_cnt_q;
  len_t       r_cnt_q;
  resp_t      b_acc_q;
  resp_t      b_merged;
  logic       b_last;
  logic       r_last;
  logic       b_beat;
  logic       r_beat;

  // Any error response wins over OKAY
  function automatic resp_t merge_resp(resp_t acc, resp_t nxt);
    return (nxt != RESP_OKAY) ? nxt : acc;
  endfunction

  assign aw_take = slv_req_i.aw_valid & slv_rsp_o.aw_ready;
  assign ar_take = slv_req_i.ar_valid & slv_rsp_o.ar_ready;
  assign aw_beat = aw_busy_q & mst_rsp_i.aw_ready;
  assign ar_beat = ar_busy_q & mst_rsp_i.ar_ready;

  assign wr_rec = '{beats: slv_req_i.aw.len, resp: RESP_OKAY};
  assign rd_rec = '{beats: slv_req_i.ar.len, resp: RESP_OKAY};

  assign b_last   = (b_cnt_q == wr_head.beats);
  assign b_merged = merge_resp(b_acc_q, mst_rsp_i.b.resp);
  assign b_beat   = mst_rsp_i.b_valid & mst_req_o.b_ready;
  assign wr_pop   = b_beat & b_last;

  assign r_last = (r_cnt_q == rd_head.beats);
  assign r_beat = mst_rsp_i.r_valid & mst_req_o.r_ready;
  assign rd_pop = r_beat & r_last;

  // Upstream side
  always_comb begin
    slv_rsp_o.aw_ready = slv_req_i.aw_valid & ~aw_busy_q & ~wr_full;
    slv_rsp_o.w_ready  = mst_rsp_i.w_ready & aw_busy_q;
    slv_rsp_o.b.id     = mst_rsp_i.b.id;
    slv_rsp_o.b.resp   = b_merged;
    // Only the final beat's response goes upstream
    slv_rsp_o.b_valid  = mst_rsp_i.b_valid & b_last & ~wr_empty;
    slv_rsp_o.ar_ready = slv_req_i.ar_valid & ~ar_busy_q & ~rd_full;
    slv_rsp_o.r        = mst_rsp_i.r;
    slv_rsp_o.r.last   = r_last;
    slv_rsp_o.r_valid  = mst_rsp_i.r_valid & ~rd_empty;
  end

  // Downstream side, single beats only
  always_comb begin
    mst_req_o.aw       = aw_q;
    mst_req_o.aw.len   = '0;
    mst_req_o.aw_valid = aw_busy_q;
    mst_req_o.w        = slv_req_i.w;
    mst_req_o.w.last   = 1'b1;
    mst_req_o.w_valid  = slv_req_i.w_valid & aw_busy_q;
    // Intermediate B responses are absorbed here
    mst_req_o.b_ready  = ~wr_empty & (~b_last | slv_req_i.b_ready);
    mst_req_o.ar       = ar_q;
    mst_req_o.ar.len   = '0;
    mst_req_o.ar_valid = ar_busy_q;
    mst_req_o.r_ready  = slv_req_i.r_ready & ~rd_empty;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_busy_q <= 1'b0;
      ar_busy_q <= 1'b0;
      b_cnt_q   <= '0;
      b_acc_q   <= RESP_OKAY;
      r_cnt_q   <= '0;
    end else begin
      if (aw_take) begin
        aw_busy_q <= 1'b1;
      end else if (aw_beat && aw_q.len == '0) begin
        aw_busy_q <= 1'b0;
      end
      if (ar_take) begin
        ar_busy_q <= 1'b1;
      end else if (ar_beat && ar_q.len == '0) begin
        ar_busy_q <= 1'b0;
      end
      if (wr_pop) begin
        b_cnt_q <= '0;
        b_acc_q <= RESP_OKAY;
      end else if (b_beat) begin
        b_cnt_q <= b_cnt_q + 1'b1;
        b_acc_q <= b_merged;
      end
      if (rd_pop) begin
        r_cnt_q <= '0;
      end else if (r_beat) begin
        r_cnt_q <= r_cnt_q + 1'b1;
      end
    end
  end

  // Burst registers, FIXED keeps the address
  always_ff @(posedge clk_i) begin
    if (aw_take) begin
      aw_q <= slv_req_i.aw;
    end else if (aw_beat) begin
      aw_q.len <= aw_q.len - 1'b1;
      if (aw_q.burst == BURST_INCR) begin
        aw_q.addr <= aw_q.addr + addr_t'(4);
      end
    end
    if (ar_take) begin
      ar_q <= slv_req_i.ar;
    end else if (ar_beat) begin
      ar_q.len <= ar_q.len - 1'b1;
      if (ar_q.burst == BURST_INCR) begin
        ar_q.addr <= ar_q.addr + addr_t'(4);
      end
    end
  end

  bridge_fifo #(
    .T     (burst_rec_t),
    .DEPTH (`AXI_MAX_TXNS)
  ) i_wr_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_take),
    .data_i  (wr_rec),
    .pop_i   (wr_pop),
    .data_o  (wr_head),
    .full_o  (wr_full),
    .empty_o (wr_empty)
  );

  bridge_fifo #(
    .T     (burst_rec_t),
    .DEPTH (`AXI_MAX_TXNS)
  ) i_rd_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (ar_take),
    .data_i  (rd_rec),
    .pop_i   (rd_pop),
    .data_o  (rd_head),
    .full_o  (rd_full),
    .empty_o (rd_empty)
  );

endmodule

`default_nettype wire

//--- src/axi_lite_id_reflect.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_defines.svh"

module axi_lite_id_reflect (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  axi_bridge_pkg::axi_req_t  slv_req_i,
  output axi_bridge_pkg::axi_rsp_t  slv_rsp_o,
  output axi_bridge_pkg::lite_req_t mst_req_o,
  input  axi_bridge_pkg::lite_rsp_t mst_rsp_i
);
  import axi_bridge_pkg::*;

  logic aw_full;
  logic aw_empty;
  logic aw_push;
  logic aw_pop;
  logic ar_full;
  logic ar_empty;
  logic ar_push;
  logic ar_pop;
  id_t  aw_id;
  id_t  ar_id;

  // Response side, IDs come back from the FIFO heads
  always_comb begin
    slv_rsp_o.aw_ready = mst_rsp_i.aw_ready & ~aw_full;
    slv_rsp_o.w_ready  = mst_rsp_i.w_ready;
    slv_rsp_o.b.id     = aw_id;
    slv_rsp_o.b.resp   = mst_rsp_i.b.resp;
    slv_rsp_o.b_valid  = mst_rsp_i.b_valid & ~aw_empty;
    slv_rsp_o.ar_ready = mst_rsp_i.ar_ready & ~ar_full;
    slv_rsp_o.r.id     = ar_id;
    slv_rsp_o.r.data   = mst_rsp_i.r.data;
    slv_rsp_o.r.resp   = mst_rsp_i.r.resp;
    // Every beat is a whole transaction here
    slv_rsp_o.r.last   = 1'b1;
    slv_rsp_o.r_valid  = mst_rsp_i.r_valid & ~ar_empty;
  end

  // Request side cropped to AXI4-Lite
  always_comb begin
    mst_req_o.aw.addr  = slv_req_i.aw.addr;
    mst_req_o.aw.prot  = slv_req_i.aw.prot;
    mst_req_o.aw_valid = slv_req_i.aw_valid & ~aw_full;
    mst_req_o.w.data   = slv_req_i.w.data;
    mst_req_o.w.strb   = slv_req_i.w.strb;
    mst_req_o.w_valid  = slv_req_i.w_valid;
    mst_req_o.b_ready  = slv_req_i.b_ready & ~aw_empty;
    mst_req_o.ar.addr  = slv_req_i.ar.addr;
    mst_req_o.ar.prot  = slv_req_i.ar.prot;
    mst_req_o.ar_valid = slv_req_i.ar_valid & ~ar_full;
    mst_req_o.r_ready  = slv_req_i.r_ready & ~ar_empty;
  end

  assign aw_push = mst_req_o.aw_valid & slv_rsp_o.aw_ready;
  assign aw_pop  = slv_rsp_o.b_valid & mst_req_o.b_ready;
  assign ar_push = mst_req_o.ar_valid & slv_rsp_o.ar_ready;
  assign ar_pop  = slv_rsp_o.r_valid & mst_req_o.r_ready;

  // Write IDs in request order
  bridge_fifo #(
    .T     (id_t),
    .DEPTH (`AXI_MAX_TXNS)
  ) i_aw_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (aw_push),
    .data_i  (slv_req_i.aw.id),
    .pop_i   (aw_pop),
    .data_o  (aw_id),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  // Read IDs in request order
  bridge_fifo #(
    .T     (id_t),
    .DEPTH (`AXI_MAX_TXNS)
  ) i_ar_id_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (ar_push),
    .data_i  (slv_req_i.ar.id),
    .pop_i   (ar_pop),
    .data_o  (ar_id),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

endmodule

`default_nettype wire

//--- src/axi_lite_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_defines.svh"

module axi_lite_mem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  axi_bridge_pkg::lite_req_t req_i,
  output axi_bridge_pkg::lite_rsp_t rsp_o
);
  import axi_bridge_pkg::*;

  localparam int unsigned IDX_W  = $clog2(`MEM_WORDS);
  localparam int unsigned STRB_W = `AXI_DATA_W / 8;

  data_t            mem_q [`MEM_WORDS];
  logic             wr_take;
  logic             rd_take;
  logic             wr_ok;
  logic             rd_ok;
  logic [IDX_W-1:0] wr_idx;
  logic [IDX_W-1:0] rd_idx;
  logic             b_pend_q;
  logic             r_pend_q;
  resp_t            b_resp_q;
  resp_t            r_resp_q;
  data_t            r_data_q;

  // AW and W are taken together, one response in flight per direction
  assign wr_take = req_i.aw_valid & req_i.w_valid & ~b_pend_q;
  assign rd_take = req_i.ar_valid & ~r_pend_q;

  assign wr_ok  = (req_i.aw.addr < addr_t'(`MEM_WORDS * 4));
  assign rd_ok  = (req_i.ar.addr < addr_t'(`MEM_WORDS * 4));
  assign wr_idx = req_i.aw.addr[IDX_W+1:2];
  assign rd_idx = req_i.ar.addr[IDX_W+1:2];

  always_comb begin
    rsp_o.aw_ready = wr_take;
    rsp_o.w_ready  = wr_take;
    rsp_o.b.resp   = b_resp_q;
    rsp_o.b_valid  = b_pend_q;
    rsp_o.ar_ready = rd_take;
    rsp_o.r.data   = r_data_q;
    rsp_o.r.resp   = r_resp_q;
    rsp_o.r_valid  = r_pend_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      b_pend_q <= 1'b0;
      r_pend_q <= 1'b0;
    end else begin
      if (wr_take) begin
        b_pend_q <= 1'b1;
      end else if (req_i.b_ready) begin
        b_pend_q <= 1'b0;
      end
      if (rd_take) begin
        r_pend_q <= 1'b1;
      end else if (req_i.r_ready) begin
        r_pend_q <= 1'b0;
      end
    end
  end

  // Storage and response payload
  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      b_resp_q <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      if (wr_ok) begin
        for (int unsigned i = 0; i < STRB_W; i++) begin
          if (req_i.w.strb[i]) begin
            mem_q[wr_idx][8*i +: 8] <= req_i.w.data[8*i +: 8];
          end
        end
      end
    end
    if (rd_take) begin
      r_resp_q <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      // Out of range reads return zero
      r_data_q <= rd_ok ? mem_q[rd_idx] : '0;
    end
  end

endmodule

`default_nettype wire

//--- src/axi_lite_bridge_top.sv
`timescale 1ns/10ps
`default_nettype none

module axi_lite_bridge_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  axi_bridge_pkg::axi_req_t slv_req_i,
  output axi_bridge_pkg::axi_rsp_t slv_rsp_o
);
  import axi_bridge_pkg::*;

  // Single-beat full AXI between splitter and ID reflect
  axi_req_t  split_req;
  axi_rsp_t  split_rsp;

  // AXI4-Lite between ID reflect and memory
  lite_req_t lite_req;
  lite_rsp_t lite_rsp;

  axi_burst_splitter i_axi_burst_splitter (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (slv_req_i),
    .slv_rsp_o (slv_rsp_o),
    .mst_req_o (split_req),
    .mst_rsp_i (split_rsp)
  );

  axi_lite_id_reflect i_axi_lite_id_reflect (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .slv_req_i (split_req),
    .slv_rsp_o (split_rsp),
    .mst_req_o (lite_req),
    .mst_rsp_i (lite_rsp)
  );

  axi_lite_mem i_axi_lite_mem (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (lite_req),
    .rsp_o   (lite_rsp)
  );

endmodule

`default_nettype wire

//--- tests/axi_lite_bridge_chk.sv
`timescale 1ns/10ps
`default_nettype none

module axi_lite_bridge_chk (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input axi_bridge_pkg::axi_req_t req_i,
  input axi_bridge_pkg::axi_rsp_t rsp_i
);
  import axi_bridge_pkg::*;

  localparam burst_t BURST_WRAP = 2'b10;

  len_t aw_len_q;
  len_t w_cnt_q;
  logic aw_xfer;
  logic w_xfer;

  assign aw_xfer = req_i.aw_valid & rsp_i.aw_ready;
  assign w_xfer  = req_i.w_valid & rsp_i.w_ready;

  // Beat position inside the current write burst
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_len_q <= '0;
      w_cnt_q  <= '0;
    end else if (aw_xfer) begin
      aw_len_q <= req_i.aw.len;
      w_cnt_q  <= '0;
    end else if (w_xfer) begin
      w_cnt_q <= w_cnt_q + 8'd1;
    end
  end

  aw_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.aw_valid && !rsp_i.aw_ready |=> req_i.aw_valid && $stable(req_i.aw))
    else $error("AW valid dropped or payload changed before ready");

  ar_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.ar_valid && !rsp_i.ar_ready |=> req_i.ar_valid && $stable(req_i.ar))
    else $error("AR valid dropped or payload changed before ready");

  no_atop: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.aw_valid |-> req_i.aw.atop == '0)
    else $error("Atomic operation on AW");

  no_wrap: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (req_i.aw_valid |-> req_i.aw.burst != BURST_WRAP) and
    (req_i.ar_valid |-> req_i.ar.burst != BURST_WRAP))
    else $error("WRAP burst requested");

  // last only on the final beat of the burst
  w_last: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    w_xfer |-> (req_i.w.last == (w_cnt_q == aw_len_q)))
    else $error("W last does not match the burst length");

endmodule

`default_nettype wire

//--- tests/axi_lite_bridge_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "axi_bridge_defines.svh"

module axi_lite_bridge_tb;
  import axi_bridge_pkg::*;

  localparam int PLANNED_BEATS  = 160;
  localparam int TIMEOUT_CYCLES = PLANNED_BEATS * 40 + 500;
  localparam int MEM_BYTES      = `MEM_WORDS * 4;

  logic     clk = 1'b0;
  logic     rst_n;
  axi_req_t drv_req;
  axi_req_t dut_req;
  axi_rsp_t dut_rsp;
  logic     b_rdy = 1'b1;
  logic     r_rdy = 1'b1;
  logic     bp_en;
  logic     reset_seen = 1'b0;
  int       n_checks = 0;
  int       n_errors = 0;
  string    test_name;

  // Responses still owed by the DUT, in request order
  b_chan_t  exp_b [$];
  r_chan_t  exp_r [$];
  b_chan_t  eb;
  r_chan_t  er;

  // Mirror of the memory, keyed by word index
  data_t    ref_mem [int unsigned];

  always #4 clk = ~clk;

  always_comb begin
    dut_req         = drv_req;
    dut_req.b_ready = b_rdy;
    dut_req.r_ready = r_rdy;
  end

  axi_lite_bridge_top axi_lite_bridge_top_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .slv_req_i (dut_req),
    .slv_rsp_o (dut_rsp)
  );

  bind axi_lite_bridge_top axi_lite_bridge_chk i_axi_lite_bridge_chk (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (slv_req_i),
    .rsp_i   (slv_rsp_o)
  );

  // Addresses past the end of memory answer with an error
  function automatic resp_t beat_resp(addr_t addr);
    return (int'(addr) < MEM_BYTES) ? RESP_OKAY : RESP_SLVERR;
  endfunction

  function automatic data_t ref_read(addr_t addr, output resp_t resp);
    int unsigned word;
    word = 32'(addr) >> 2;
    resp = beat_resp(addr);
    if (resp != RESP_OKAY) begin
      return '0;
    end
    if (ref_mem.exists(word)) begin
      return ref_mem[word];
    end
    return 'x;
  endfunction

  function automatic void ref_write(addr_t addr, data_t data, strb_t strb);
    int unsigned word;
    data_t       cur;
    int          i;
    word = 32'(addr) >> 2;
    if (beat_resp(addr) == RESP_OKAY) begin
      cur = ref_mem.exists(word) ? ref_mem[word] : 'x;
      for (i = 0; i < $bits(strb_t); i++) begin
        if (strb[i]) begin
          cur[8*i +: 8] = data[8*i +: 8];
        end
      end
      ref_mem[word] = cur;
    end
  endfunction

  task automatic check_val(string name, logic [63:0] exp_v, logic [63:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, name, exp_v, act_v);
    end
  endtask

  task automatic write_burst(id_t id, addr_t addr, int len, burst_t burst, strb_t strb);
    aw_chan_t aw;
    w_chan_t  w;
    b_chan_t  b;
    addr_t    a;
    data_t    d;
    int       i;
    a      = addr;
    aw     = '0;
    aw.id  = id;
    aw.addr  = addr;
    aw.len   = len_t'(len);
    aw.size  = 3'd2;
    aw.burst = burst;
    b.id   = id;
    b.resp = RESP_OKAY;
    @(posedge clk);
    drv_req.aw       <= aw;
    drv_req.aw_valid <= 1'b1;
    @(posedge clk);
    while (!dut_rsp.aw_ready) @(posedge clk);
    drv_req.aw_valid <= 1'b0;
    for (i = 0; i <= len; i++) begin
      d      = $urandom;
      w.data = d;
      w.strb = strb;
      w.last = (i == len);
      drv_req.w       <= w;
      drv_req.w_valid <= 1'b1;
      @(posedge clk);
      while (!dut_rsp.w_ready) @(posedge clk);
      ref_write(a, d, strb);
      // An error on any beat wins
      if (beat_resp(a) == RESP_SLVERR) begin
        b.resp = RESP_SLVERR;
      end
      if (burst == BURST_INCR) begin
        a = a + addr_t'(4);
      end
    end
    drv_req.w_valid <= 1'b0;
    exp_b.push_back(b);
  endtask

  task automatic read_burst(id_t id, addr_t addr, int len, burst_t burst);
    ar_chan_t ar;
    r_chan_t  r;
    addr_t    a;
    resp_t    resp;
    int       i;
    a = addr;
    for (i = 0; i <= len; i++) begin
      r.id   = id;
      r.data = ref_read(a, resp);
      r.resp = resp;
      r.last = (i == len);
      exp_r.push_back(r);
      if (burst == BURST_INCR) begin
        a = a + addr_t'(4);
      end
    end
    ar       = '0;
    ar.id    = id;
    ar.addr  = addr;
    ar.len   = len_t'(len);
    ar.size  = 3'd2;
    ar.burst = burst;
    @(posedge clk);
    drv_req.ar       <= ar;
    drv_req.ar_valid <= 1'b1;
    @(posedge clk);
    while (!dut_rsp.ar_ready) @(posedge clk);
    drv_req.ar_valid <= 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_b.size() != 0 || exp_r.size() != 0) @(posedge clk);
    @(posedge clk);
  endtask

  // Random back-pressure on B and R
  always @(posedge clk) begin
    if (bp_en) begin
      b_rdy <= ($urandom_range(0, 3) != 0);
      r_rdy <= ($urandom_range(0, 3) != 0);
    end else begin
      b_rdy <= 1'b1;
      r_rdy <= 1'b1;
    end
  end

  // Compare process
  always @(posedge clk) begin
    if (rst_n) begin
      if (!reset_seen) begin
        check_val("idle after reset", 64'd0, 64'({dut_rsp.aw_ready, dut_rsp.w_ready,
          dut_rsp.b_valid, dut_rsp.ar_ready, dut_rsp.r_valid}));
        reset_seen <= 1'b1;
      end
      if (dut_rsp.b_valid && dut_req.b_ready) begin
        if (exp_b.size() == 0) begin
          n_errors++;
          $display("Test %s got a write response that no request asked for", test_name);
        end else begin
          eb = exp_b.pop_front();
          check_val("b.id", 64'(eb.id), 64'(dut_rsp.b.id));
          check_val("b.resp", 64'(eb.resp), 64'(dut_rsp.b.resp));
        end
      end
      if (dut_rsp.r_valid && dut_req.r_ready) begin
        if (exp_r.size() == 0) begin
          n_errors++;
          $display("Test %s got a read beat that no request asked for", test_name);
        end else begin
          er = exp_r.pop_front();
          check_val("r.id", 64'(er.id), 64'(dut_rsp.r.id));
          check_val("r.data", 64'(er.data), 64'(dut_rsp.r.data));
          check_val("r.resp", 64'(er.resp), 64'(dut_rsp.r.resp));
          check_val("r.last", 64'(er.last), 64'(dut_rsp.r.last));
        end
      end
    end
  end

  initial begin
    int i;
    int len;
    int idx;
    void'($urandom(32));
    drv_req <= '0;
    rst_n   <= 1'b0;
    bp_en   <= 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    test_name = "single";
    write_burst(4'h3, 16'h0010, 0, BURST_INCR, 4'hf);
    read_burst(4'h5, 16'h0010, 0, BURST_INCR);
    wait_idle();

    test_name = "strobe";
    write_burst(4'h1, 16'h0020, 0, BURST_INCR, 4'hf);
    write_burst(4'h2, 16'h0020, 0, BURST_INCR, 4'b0101);
    write_burst(4'h3, 16'h0020, 0, BURST_INCR, 4'b1000);
    read_burst(4'h4, 16'h0020, 0, BURST_INCR);
    wait_idle();

    test_name = "incr";
    for (i = 0; i < 6; i++) begin
      idx = $urandom_range(64, 240);
      len = $urandom_range(0, 7);
      write_burst(id_t'($urandom_range(0, 15)), addr_t'(idx * 4), len, BURST_INCR, 4'hf);
      read_burst(id_t'($urandom_range(0, 15)), addr_t'(idx * 4), len, BURST_INCR);
      wait_idle();
    end

    test_name = "fixed";
    write_burst(4'h6, 16'h0040, 3, BURST_FIXED, 4'hf);
    read_burst(4'h7, 16'h0040, 3, BURST_FIXED);
    wait_idle();

    test_name = "ids";
    bp_en <= 1'b1;
    write_burst(id_t'($urandom_range(0, 15)), 16'h0200, 7, BURST_INCR, 4'hf);
    for (i = 0; i < 3; i++) begin
      write_burst(id_t'($urandom_range(0, 15)), addr_t'(16'h0220 + i * 4), 0,
                  BURST_INCR, 4'hf);
    end
    wait_idle();
    // More reads than the bridge keeps in flight
    for (i = 0; i < 2 * `AXI_MAX_TXNS; i++) begin
      idx = $urandom_range(0, 9);
      read_burst(id_t'($urandom_range(0, 15)), addr_t'(16'h0200 + idx * 4),
                 $urandom_range(0, 1), BURST_INCR);
    end
    wait_idle();
    bp_en <= 1'b0;

    test_name = "range";
    write_burst(4'h8, addr_t'(MEM_BYTES), 0, BURST_INCR, 4'hf);
    read_burst(4'h9, addr_t'(MEM_BYTES), 0, BURST_INCR);
    wait_idle();
    // Two beats inside, two beyond the end
    write_burst(4'ha, addr_t'(MEM_BYTES - 8), 3, BURST_INCR, 4'hf);
    read_burst(4'hb, addr_t'(MEM_BYTES - 8), 3, BURST_INCR);
    wait_idle();

    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Run timed out after %0d cycles in test %s with %0d B and %0d R responses owed",
             TIMEOUT_CYCLES, test_name, exp_b.size(), exp_r.size());
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/axi_bridge_pkg.sv
src/bridge_fifo.sv
src/axi_burst_splitter.sv
src/axi_lite_id_reflect.sv
src/axi_lite_mem.sv
src/axi_lite_bridge_top.sv
tests/axi_lite_bridge_chk.sv
tests/axi_lite_bridge_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=axi_lite_bridge_sim

verilator --binary --timing --assert -j 0 \
  --top-module axi_lite_bridge_tb \
  -Mdir obj_dir -o "$BIN" \
  -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^TESTBENCH PASSED$" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
